// ==== bench/femto_tb.sv ====
module femto_tb;
    import femto_pkg::*;

    localparam int   N_WORDS  = 16;
    localparam int   N_CONT   = 12;
    localparam int   N_ACCESS = 4 * N_WORDS + 2 * N_CONT + 20;
    localparam logic DBUS     = 1'b0;
    localparam logic IBUS     = 1'b1;

    // one completed bus access
    typedef struct packed {
        logic       ibus;
        logic       chk_lat;
        logic [7:0] lat;
        wb_req_t    req;
        wb_rsp_t    rsp;
    } txn_t;

    logic                  clk;
    logic                  rstn;
    wb_req_t               ibus_req;
    wb_rsp_t               ibus_rsp;
    wb_req_t               dbus_req;
    wb_rsp_t               dbus_rsp;
    logic [GPIO_WIDTH-1:0] gpio_i;
    logic [GPIO_WIDTH-1:0] gpio_o;
    logic [GPIO_WIDTH-1:0] gpio_oe;

    // shadow of the tcm and the gpio registers
    logic [31:0] shadow_mem [1024];
    logic [15:0] shadow_out;
    logic [15:0] shadow_dir;
    logic [15:0] shadow_in;

    logic [31:0] lfsr = 32'h6b3d;
    string       test_name;
    txn_t        txn_q[$];
    event        txn_ev;
    int          issued [2];
    int          rsp_cnt [2];
    logic [9:0]  idx_list [N_WORDS];
    logic [9:0]  cont_d [N_CONT];
    logic [9:0]  cont_i [N_CONT];
    logic [31:0] cont_w [N_CONT];

    femto_fabric UUT (
        .clk     (clk),
        .rstn    (rstn),
        .ibus_req(ibus_req),
        .ibus_rsp(ibus_rsp),
        .dbus_req(dbus_req),
        .dbus_rsp(dbus_rsp),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .gpio_oe (gpio_oe)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] word_adr(input logic [9:0] i);
        return {20'h0, i, 2'b00};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // tcm is 4 KiB at 0 and gpio 16 bytes at 0x1000_0000 on the data bus only
    function automatic wb_rsp_t ref_rsp(input logic ibus, input wb_req_t r);
        wb_rsp_t e;
        e = '0;
        if (r.adr < 32'h0000_1000) begin
            e.ack = 1'b1;
            e.dat = shadow_mem[r.adr[11:2]];
        end else if (!ibus && r.adr[31:4] == 28'h100_0000) begin
            e.ack = 1'b1;
            case (r.adr[3:0])
                4'h0:    e.dat = {16'h0, shadow_out};
                4'h4:    e.dat = {16'h0, shadow_dir};
                4'h8:    e.dat = {16'h0, shadow_in};
                default: e.dat = '0;
            endcase
        end else begin
            e.err = 1'b1;
        end
        return e;
    endfunction

    function automatic logic [15:0] merge_low(input logic [15:0] cur, input wb_req_t r);
        for (int b = 0; b < 2; b++) begin
            if (r.sel[b]) begin
                cur[8*b +: 8] = r.dat[8*b +: 8];
            end
        end
        return cur;
    endfunction

    task automatic apply_write(input wb_req_t r);
        if (r.adr < 32'h0000_1000) begin
            for (int b = 0; b < 4; b++) begin
                if (r.sel[b]) begin
                    shadow_mem[r.adr[11:2]][8*b +: 8] = r.dat[8*b +: 8];
                end
            end
        end else if (r.adr[3:0] == 4'h0) begin
            shadow_out = merge_low(shadow_out, r);
        end else if (r.adr[3:0] == 4'h4) begin
            shadow_dir = merge_low(shadow_dir, r);
        end
    endtask

    // one wishbone classic access with lat counting edges until the response
    task automatic bus_access(input logic ibus, input logic we, input logic [3:0] sel,
                              input logic [31:0] adr, input logic [31:0] dat,
                              input logic chk_lat);
        wb_req_t r;
        txn_t    t;
        r = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        t = '0;
        @(posedge clk);
        if (ibus) ibus_req <= r;
        else dbus_req <= r;
        do begin
            @(negedge clk);
            t.rsp = ibus ? ibus_rsp : dbus_rsp;
            if (!(t.rsp.ack || t.rsp.err)) t.lat = t.lat + 8'd1;
        end while (!(t.rsp.ack || t.rsp.err));
        t.ibus    = ibus;
        t.chk_lat = chk_lat;
        t.req     = r;
        txn_q.push_back(t);
        issued[ibus]++;
        -> txn_ev;
        @(posedge clk);
        if (ibus) ibus_req <= '0;
        else dbus_req <= '0;
    endtask

    // compare in completion order so the shadow follows the tcm
    initial begin
        txn_t    t;
        wb_rsp_t e;
        forever begin
            @(txn_ev);
            while (txn_q.size() > 0) begin
                t = txn_q.pop_front();
                e = ref_rsp(t.ibus, t.req);
                check_val({test_name, " ack"}, 32'(e.ack), 32'(t.rsp.ack));
                check_val({test_name, " err"}, 32'(e.err), 32'(t.rsp.err));
                if (!t.req.we && e.ack) check_val({test_name, " data"}, e.dat, t.rsp.dat);
                if (t.chk_lat) check_val({test_name, " latency"}, 32'd1, 32'(t.lat));
                if (t.req.we && e.ack) apply_write(t.req);
            end
        end
    end

    // count every response pulse to catch lost or doubled ones
    always @(negedge clk) begin
        if (rstn) begin
            if (ibus_rsp.ack || ibus_rsp.err) rsp_cnt[1]++;
            if (dbus_rsp.ack || dbus_rsp.err) rsp_cnt[0]++;
        end
    end

    initial begin
        repeat (N_ACCESS * 20 + 100) @(posedge clk);
        $display("timeout: bus accesses did not finish in %0d clock periods",
                 N_ACCESS * 20 + 100);
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        logic [31:0] v;
        logic [31:0] a;
        ibus_req   = '0;
        dbus_req   = '0;
        gpio_i     = '0;
        rstn       = 1'b0;
        shadow_out = '0;
        shadow_dir = '0;
        shadow_in  = '0;
        test_name  = "reset";
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_val("reset_rsp", 32'd0,
                      32'({ibus_rsp.ack, ibus_rsp.err, dbus_rsp.ack, dbus_rsp.err}));
            check_val("reset_gpio", 32'd0, {gpio_oe, gpio_o});
        end

        test_name = "tcm_write_read";
        for (int k = 0; k < N_WORDS; k++) begin
            v           = rand_bits(10);
            idx_list[k] = v[9:0];
            bus_access(DBUS, 1'b1, 4'hf, word_adr(v[9:0]), rand_bits(32), 1'b1);
        end
        for (int k = 0; k < N_WORDS; k++) begin
            v = rand_bits(4);
            bus_access(DBUS, 1'b1, v[3:0], word_adr(idx_list[k]), rand_bits(32), 1'b1);
        end
        for (int k = 0; k < N_WORDS; k++) begin
            bus_access(DBUS, 1'b0, 4'hf, word_adr(idx_list[k]), 32'h0, 1'b1);
        end

        test_name = "ibus_read";
        for (int k = 0; k < N_WORDS; k++) begin
            bus_access(IBUS, 1'b0, 4'hf, word_adr(idx_list[k]), 32'h0, 1'b1);
        end
        bus_access(IBUS, 1'b1, 4'h3, word_adr(idx_list[0]), rand_bits(32), 1'b1);
        bus_access(DBUS, 1'b0, 4'hf, word_adr(idx_list[0]), 32'h0, 1'b1);

        test_name = "contention";
        for (int k = 0; k < N_CONT; k++) begin
            v         = rand_bits(8);
            cont_d[k] = idx_list[v[3:0]];
            cont_i[k] = idx_list[v[7:4]];
            cont_w[k] = rand_bits(32);
        end
        fork
            for (int k = 0; k < N_CONT; k++) begin
                bus_access(DBUS, k[0] == 1'b0, 4'hf, word_adr(cont_d[k]), cont_w[k], 1'b0);
            end
            for (int k = 0; k < N_CONT; k++) begin
                bus_access(IBUS, 1'b0, 4'hf, word_adr(cont_i[k]), 32'h0, 1'b0);
            end
        join

        test_name = "gpio";
        bus_access(DBUS, 1'b1, 4'hf, 32'h1000_0000, rand_bits(32), 1'b1);
        bus_access(DBUS, 1'b1, 4'h3, 32'h1000_0004, rand_bits(32), 1'b1);
        bus_access(DBUS, 1'b1, 4'h2, 32'h1000_0000, rand_bits(32), 1'b1);
        @(negedge clk);
        check_val("gpio_pins", {shadow_dir, shadow_out & shadow_dir}, {gpio_oe, gpio_o});
        bus_access(DBUS, 1'b0, 4'hf, 32'h1000_0000, 32'h0, 1'b1);
        bus_access(DBUS, 1'b0, 4'hf, 32'h1000_0004, 32'h0, 1'b1);
        bus_access(DBUS, 1'b0, 4'hf, 32'h1000_000c, 32'h0, 1'b1);
        bus_access(DBUS, 1'b1, 4'hf, 32'h1000_0008, rand_bits(32), 1'b1);
        v = rand_bits(16);
        @(posedge clk);
        gpio_i    <= v[15:0];
        shadow_in  = v[15:0];
        repeat (3) @(posedge clk);
        bus_access(DBUS, 1'b0, 4'hf, 32'h1000_0008, 32'h0, 1'b1);

        test_name = "unmapped";
        a = word_adr(idx_list[1]);
        bus_access(DBUS, 1'b1, 4'hf, 32'h2000_0000 | a, rand_bits(32), 1'b1);
        bus_access(DBUS, 1'b0, 4'hf, 32'h8000_0000, 32'h0, 1'b1);
        bus_access(IBUS, 1'b0, 4'hf, 32'h1000_0000, 32'h0, 1'b1);
        bus_access(IBUS, 1'b1, 4'hf, 32'h1000_0004, 32'hffff_ffff, 1'b1);
        bus_access(IBUS, 1'b1, 4'hf, 32'h0000_1000 | a, rand_bits(32), 1'b1);
        bus_access(DBUS, 1'b0, 4'hf, a, 32'h0, 1'b1);
        bus_access(DBUS, 1'b0, 4'hf, 32'h1000_0004, 32'h0, 1'b1);

        // a doubled last response shows up one edge later
        @(negedge clk);
        check_val("ibus_responses", issued[1], rsp_cnt[1]);
        check_val("dbus_responses", issued[0], rsp_cnt[0]);
        $display("No errors");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module femto_tb -f sim.f &&
./obj_dir/Vfemto_tb | tee /dev/stderr | grep -qx "No errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim.f ====
verilog/femto_pkg.sv
verilog/bus_decoder.sv
verilog/bus_arbiter.sv
verilog/tcm_controller.sv
verilog/gpio_controller.sv
verilog/femto_fabric.sv
bench/femto_tb.sv

// ==== verilog/bus_arbiter.sv ====
module bus_arbiter (
    input  logic               clk,
    input  logic               rstn,
    input  femto_pkg::wb_req_t ireq,
    output femto_pkg::wb_rsp_t irsp,
    input  femto_pkg::wb_req_t dreq,
    output femto_pkg::wb_rsp_t drsp,
    output femto_pkg::wb_req_t sreq,
    input  femto_pkg::wb_rsp_t srsp
);
    import femto_pkg::*;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic [1:0] grant;
    logic       done;

    assign done = srsp.ack | srsp.err;

    // combinational grant keeps an uncontested access at one cycle
    always_comb begin
        case (state)
            ARB_IBUS: begin
                if (ireq.stb) begin
                    grant = ARB_IBUS;
                end else if (dreq.stb) begin
                    grant = ARB_DBUS;
                end else begin
                    grant = ARB_IDLE;
                end
            end
            // idle and data owner both look at data first
            default: begin
                if (dreq.stb) begin
                    grant = ARB_DBUS;
                end else if (ireq.stb) begin
                    grant = ARB_IBUS;
                end else begin
                    grant = ARB_IDLE;
                end
            end
        endcase
    end

    // hand over on completion when the other side is waiting
    always_comb begin
        state_nxt = grant;
        if (done) begin
            if (grant == ARB_IBUS && dreq.stb) begin
                state_nxt = ARB_DBUS;
            end else if (grant == ARB_DBUS && ireq.stb) begin
                state_nxt = ARB_IBUS;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // loser sees nothing, which holds it off
    always_comb begin
        sreq     = '0;
        irsp     = '0;
        drsp     = '0;
        irsp.dat = srsp.dat;
        drsp.dat = srsp.dat;
        case (grant)
            ARB_IBUS: begin
                sreq = ireq;
                irsp = srsp;
            end
            ARB_DBUS: begin
                sreq = dreq;
                drsp = srsp;
            end
            default: begin
                sreq = '0;
            end
        endcase
    end

    // an ack only answers a strobe that was already pending
    a_ack_owner: assert property (@(posedge clk) disable iff (!rstn)
        (irsp.ack |-> $past(ireq.stb)) and (drsp.ack |-> $past(dreq.stb)));

    // each ack lands on the registered owner, so the two never overlap
    a_single_ack: assert property (@(posedge clk) disable iff (!rstn)
        (irsp.ack |-> state == ARB_IBUS) and (drsp.ack |-> state == ARB_DBUS));

endmodule

// ==== verilog/bus_decoder.sv ====
module bus_decoder #(
    parameter bit GPIO_EN = 1'b1
) (
    input  logic               clk,
    input  logic               rstn,
    input  femto_pkg::wb_req_t mreq,
    output femto_pkg::wb_rsp_t mrsp,
    output femto_pkg::wb_req_t tcm_req,
    input  femto_pkg::wb_rsp_t tcm_rsp,
    output femto_pkg::wb_req_t gpio_req,
    input  femto_pkg::wb_rsp_t gpio_rsp
);
    import femto_pkg::*;

    logic tcm_sel;
    logic gpio_sel;
    logic miss;
    logic err_q;

    assign tcm_sel  = (mreq.adr & TCM_SEL_MASK) == TCM_ADDR;
    // instruction side never decodes the gpio window
    assign gpio_sel = GPIO_EN && ((mreq.adr & GPIO_SEL_MASK) == GPIO_ADDR);
    assign miss     = !tcm_sel && !gpio_sel;

    // payload goes everywhere, strobes only to the match
    always_comb begin
        tcm_req      = mreq;
        tcm_req.cyc  = mreq.cyc & tcm_sel;
        tcm_req.stb  = mreq.stb & tcm_sel;
        gpio_req     = mreq;
        gpio_req.cyc = mreq.cyc & gpio_sel;
        gpio_req.stb = mreq.stb & gpio_sel;
    end

    // one-cycle error for an unmapped address
    always_ff @(posedge clk) begin
        if (!rstn) begin
            err_q <= 1'b0;
        end else begin
            err_q <= mreq.cyc & mreq.stb & miss & !err_q;
        end
    end

    // address is held until the response, so route on the live match
    always_comb begin
        mrsp = '0;
        if (tcm_sel) begin
            mrsp = tcm_rsp;
        end else if (gpio_sel) begin
            mrsp = gpio_rsp;
        end
        mrsp.err = mrsp.err | err_q;
    end

    // a pending error never overlaps a forwarded strobe
    a_one_target: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({tcm_req.stb, gpio_req.stb, err_q}));

endmodule

// ==== verilog/femto_fabric.sv ====
module femto_fabric (
    input  logic                             clk,
    input  logic                             rstn,
    input  femto_pkg::wb_req_t               ibus_req,
    output femto_pkg::wb_rsp_t               ibus_rsp,
    input  femto_pkg::wb_req_t               dbus_req,
    output femto_pkg::wb_rsp_t               dbus_rsp,
    input  logic [femto_pkg::GPIO_WIDTH-1:0] gpio_i,
    output logic [femto_pkg::GPIO_WIDTH-1:0] gpio_o,
    output logic [femto_pkg::GPIO_WIDTH-1:0] gpio_oe
);
    import femto_pkg::*;

    // decoder to arbiter
    wb_req_t i_tcm_req;
    wb_rsp_t i_tcm_rsp;
    wb_req_t d_tcm_req;
    wb_rsp_t d_tcm_rsp;

    // arbiter to memory
    wb_req_t tcm_req;
    wb_rsp_t tcm_rsp;

    wb_req_t d_gpio_req;
    wb_rsp_t d_gpio_rsp;

    // instruction side has no gpio path
    bus_decoder #(
        .GPIO_EN(1'b0)
    ) i_decoder (
        .clk     (clk),
        .rstn    (rstn),
        .mreq    (ibus_req),
        .mrsp    (ibus_rsp),
        .tcm_req (i_tcm_req),
        .tcm_rsp (i_tcm_rsp),
        .gpio_req(),
        .gpio_rsp('0)
    );

    bus_decoder #(
        .GPIO_EN(1'b1)
    ) d_decoder (
        .clk     (clk),
        .rstn    (rstn),
        .mreq    (dbus_req),
        .mrsp    (dbus_rsp),
        .tcm_req (d_tcm_req),
        .tcm_rsp (d_tcm_rsp),
        .gpio_req(d_gpio_req),
        .gpio_rsp(d_gpio_rsp)
    );

    bus_arbiter tcm_arbiter (
        .clk (clk),
        .rstn(rstn),
        .ireq(i_tcm_req),
        .irsp(i_tcm_rsp),
        .dreq(d_tcm_req),
        .drsp(d_tcm_rsp),
        .sreq(tcm_req),
        .srsp(tcm_rsp)
    );

    tcm_controller tcm_controller (
        .clk (clk),
        .rstn(rstn),
        .req (tcm_req),
        .rsp (tcm_rsp)
    );

    gpio_controller gpio_controller (
        .clk    (clk),
        .rstn   (rstn),
        .req    (d_gpio_req),
        .rsp    (d_gpio_rsp),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o),
        .gpio_oe(gpio_oe)
    );

endmodule

// ==== verilog/femto_pkg.sv ====
package femto_pkg;

    localparam int XLEN      = 32;
    localparam int BUS_WIDTH = 32;
    localparam int SEL_WIDTH = BUS_WIDTH / 8;

    // a target matches when (adr & mask) == base
    localparam logic [XLEN-1:0] TCM_ADDR      = 32'h0000_0000;
    localparam logic [XLEN-1:0] TCM_SEL_MASK  = 32'hffff_f000;
    localparam logic [XLEN-1:0] GPIO_ADDR     = 32'h1000_0000;
    localparam logic [XLEN-1:0] GPIO_SEL_MASK = 32'hffff_fff0;

    // tcm geometry in words
    localparam int TCM_WORDS = 1024;
    localparam int TCM_AW    = $clog2(TCM_WORDS);

    localparam int GPIO_WIDTH = 16;

    // gpio register byte offsets
    localparam logic [3:0] GPIO_REG_OUT = 4'h0;
    localparam logic [3:0] GPIO_REG_DIR = 4'h4;
    localparam logic [3:0] GPIO_REG_IN  = 4'h8;

    // tcm arbiter owner encoding
    localparam logic [1:0] ARB_IDLE = 2'd0;
    localparam logic [1:0] ARB_IBUS = 2'd1;
    localparam logic [1:0] ARB_DBUS = 2'd2;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [SEL_WIDTH-1:0] sel;
        logic [XLEN-1:0]      adr;
        logic [BUS_WIDTH-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic [BUS_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

// ==== verilog/gpio_controller.sv ====
module gpio_controller (
    input  logic                               clk,
    input  logic                               rstn,
    input  femto_pkg::wb_req_t                 req,
    output femto_pkg::wb_rsp_t                 rsp,
    input  logic [femto_pkg::GPIO_WIDTH-1:0]   gpio_i,
    output logic [femto_pkg::GPIO_WIDTH-1:0]   gpio_o,
    output logic [femto_pkg::GPIO_WIDTH-1:0]   gpio_oe
);
    import femto_pkg::*;

    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] dir_q;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;
    logic [3:0]            reg_off;
    logic                  access;
    logic                  wr;
    logic                  ack_q;
    logic [BUS_WIDTH-1:0]  rdat;
    logic [BUS_WIDTH-1:0]  rdat_q;

    function automatic logic [GPIO_WIDTH-1:0] lane_merge(
        input logic [GPIO_WIDTH-1:0] cur,
        input logic [BUS_WIDTH-1:0]  wdat,
        input logic [SEL_WIDTH-1:0]  sel
    );
        logic [GPIO_WIDTH-1:0] res;
        res = cur;
        for (int b = 0; b < GPIO_WIDTH / 8; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign reg_off = req.adr[3:0];
    assign access  = req.cyc & req.stb & !ack_q;
    assign wr      = access & req.we;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_q   <= '0;
            dir_q   <= '0;
            in_meta <= '0;
            in_sync <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q   <= access;
            // two-flop input sync
            in_meta <= gpio_i;
            in_sync <= in_meta;
            if (wr && reg_off == GPIO_REG_OUT) begin
                out_q <= lane_merge(out_q, req.dat, req.sel);
            end
            if (wr && reg_off == GPIO_REG_DIR) begin
                dir_q <= lane_merge(dir_q, req.dat, req.sel);
            end
        end
    end

    // unused offsets read zero
    always_comb begin
        rdat = '0;
        case (reg_off)
            GPIO_REG_OUT: rdat[GPIO_WIDTH-1:0] = out_q;
            GPIO_REG_DIR: rdat[GPIO_WIDTH-1:0] = dir_q;
            GPIO_REG_IN:  rdat[GPIO_WIDTH-1:0] = in_sync;
            default:      rdat = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdat_q <= rdat;
        end
    end

    assign rsp     = '{ack: ack_q, err: 1'b0, dat: rdat_q};
    assign gpio_o  = out_q & dir_q;
    assign gpio_oe = dir_q;

endmodule

// ==== verilog/tcm_controller.sv ====
module tcm_controller (
    input  logic               clk,
    input  logic               rstn,
    input  femto_pkg::wb_req_t req,
    output femto_pkg::wb_rsp_t rsp
);
    import femto_pkg::*;

    logic [BUS_WIDTH-1:0] mem [TCM_WORDS];
    logic [TCM_AW-1:0]    widx;
    logic                 access;
    logic                 ack_q;
    logic [BUS_WIDTH-1:0] rdat_q;

    // word index above the byte offset
    assign widx   = req.adr[TCM_AW+1:2];
    assign access = req.cyc & req.stb & !ack_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // lane-masked write, full-word read
    always_ff @(posedge clk) begin
        if (access) begin
            if (req.we) begin
                for (int b = 0; b < SEL_WIDTH; b++) begin
                    if (req.sel[b]) begin
                        mem[widx][8*b +: 8] <= req.dat[8*b +: 8];
                    end
                end
            end
            rdat_q <= mem[widx];
        end
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdat_q};

    // master still strobes when the ack comes back
    a_ack_after_stb: assert property (@(posedge clk) disable iff (!rstn)
        rsp.ack |-> req.cyc && req.stb);

endmodule
